// ==== iClassPred.f ====
logic/iClassPkg.sv
logic/classBus.sv
logic/fetchPredecode.sv
logic/decodeClassify.sv
logic/classPipe.sv
logic/iClassPred.sv
verification/iClassPredTb.sv

// ==== logic/classBus.sv ====
/* Class bus
   D-stage class bits and class-mismatch flag between pipeline blocks */
`timescale 1ns/1ps

interface classBus;

  // Class bits, same meaning as iClass_t
  logic call;
  logic ret;
  logic jump;
  logic branch;
  // Predicted class differs from decoded class
  logic wrong;

  // Decode side
  modport sender (
    output call, ret, jump, branch, wrong
  );

  // Pipeline side
  modport receiver (
    input call, ret, jump, branch, wrong
  );

endinterface

// ==== logic/classPipe.sv ====
/* Class pipeline
   Carries the D-stage class through E, M and W with per-stage stall and flush */
`timescale 1ns/1ps

module classPipe
  import iClassPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  logic      stallE,
  input  logic      stallM,
  input  logic      stallW,
  input  logic      flushE,
  input  logic      flushM,
  input  logic      flushW,
  classBus.receiver dBus,
  output iClass_t   classE,
  output iClass_t   classM,
  output iClass_t   classW,
  output logic      classWrongE,
  output logic      classWrongM
);

  // Repack the bus into a class vector
  iClass_t classD;

  assign classD = {dBus.call, dBus.ret, dBus.jump, dBus.branch};

  ////////////////////////////////////////////////////////////
  // Execute register, class and wrong flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      classE      <= '0;
      classWrongE <= 1'b0;
    end else if (!stallE) begin
      // Flush loads a bubble
      classE      <= flushE ? '0 : classD;
      classWrongE <= flushE ? 1'b0 : dBus.wrong;
    end
  end

  ////////////////////////////////////////////////////////////
  // Memory register, class and wrong flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      classM      <= '0;
      classWrongM <= 1'b0;
    end else if (!stallM) begin
      classM      <= flushM ? '0 : classE;
      classWrongM <= flushM ? 1'b0 : classWrongE;
    end
  end

  ////////////////////////////////////////////////////////////
  // Writeback register, class only
  ////////////////////////////////////////////////////////////

  // Wrong flag is not needed past M
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      classW <= '0;
    end else if (!stallW) begin
      classW <= flushW ? '0 : classM;
    end
  end

endmodule

// ==== logic/decodeClassify.sv ====
/* Decode classification
   Classes the decode instruction and checks it against the predicted class */
`timescale 1ns/1ps

module decodeClassify
  import iClassPkg::*;
(
  input  instr_t  instrD,
  input  iClass_t bpClassD,
  output logic    returnWrongD,
  classBus.sender dBus
);

  // Decoded class of the D-stage word
  iClass_t classD;
  // Per-bit disagreement with the prediction
  iClass_t diffD;

  ////////////////////////////////////////////////////////////
  // Classify
  ////////////////////////////////////////////////////////////

  // Same 32-bit rules as predecode; jump and branch come
  // straight from the opcode here
  assign classD = classify32(instrD);

  assign diffD = classD ^ bpClassD;

  ////////////////////////////////////////////////////////////
  // Drive the D-stage bundle
  ////////////////////////////////////////////////////////////

  assign dBus.call   = classD[clsCall];
  assign dBus.ret    = classD[clsRet];
  assign dBus.jump   = classD[clsJump];
  assign dBus.branch = classD[clsBranch];

  // Any class bit wrong
  assign dBus.wrong = |diffD;

  // Return mispredict gets its own flag for the return stack path
  assign returnWrongD = diffD[clsRet];

endmodule

// ==== logic/fetchPredecode.sv ====
/* Fetch predecode
   Partial decode of the raw fetch word into call, return, jump and branch,
   with the predicted class registered into Decode */
`timescale 1ns/1ps

module fetchPredecode
  import iClassPkg::*;
#(
  parameter bit cSupported = 1'b1,
  parameter int xlen       = 32
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    stallD,
  input  logic    flushD,
  input  instr_t  instrRawF,
  output iClass_t bpClassF,
  output iClass_t bpClassD
);

  ////////////////////////////////////////////////////////////
  // Full-width decode
  ////////////////////////////////////////////////////////////

  iClass_t fullClassF;
  iClass_t compClassF;

  assign fullClassF = classify32(instrRawF);

  ////////////////////////////////////////////////////////////
  // Compressed decode
  ////////////////////////////////////////////////////////////

  if (cSupported) begin : gCompressed
    logic [4:0] cOpcF;
    logic       rs2Zero;
    logic       rs1NonZero;
    logic       linkRs1;
    logic       cCall;
    logic       cJ;
    logic       cJr;
    logic       cJalr;
    logic       cJumpF;
    logic       cBranchF;

    assign cOpcF      = {instrRawF[1:0], instrRawF[15:13]};
    // C.JR / C.JALR need rs2 of zero and a real rs1
    assign rs2Zero    = instrRawF[6:2] == 5'b0;
    assign rs1NonZero = instrRawF[11:7] != 5'b0;
    assign linkRs1    = isLink(instrRawF[11:7]);

    // C.JAL only exists on RV32, it is C.ADDIW on RV64
    assign cCall = (cOpcF == cOpcJal) && (xlen == 32);
    assign cJ    = cOpcF == cOpcJ;
    assign cJr   = (cOpcF == cOpcJrGroup) && !instrRawF[12] && rs2Zero && rs1NonZero;
    assign cJalr = (cOpcF == cOpcJrGroup) && instrRawF[12] && rs2Zero && rs1NonZero;

    assign cJumpF   = cCall | cJ | cJr | cJalr;
    assign cBranchF = cOpcF[4:1] == cOpcBranchPair[4:1];

    // Return through a link reg, call when C.JALR links or C.JAL
    assign compClassF[clsCall]   = cCall | (cJalr & linkRs1);
    assign compClassF[clsRet]    = (cJr | cJalr) & linkRs1;
    assign compClassF[clsJump]   = cJumpF;
    assign compClassF[clsBranch] = cBranchF;
  end else begin : gNoCompressed
    assign compClassF = '0;
  end

  // Compressed words never end in 2'b11, so the two decodes never overlap
  assign bpClassF = fullClassF | compClassF;

  ////////////////////////////////////////////////////////////
  // F to D prediction register
  ////////////////////////////////////////////////////////////

  // Flush only takes effect when not stalled
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      bpClassD <= '0;
    end else if (!stallD) begin
      if (flushD) begin
        bpClassD <= '0;
      end else begin
        bpClassD <= bpClassF;
      end
    end
  end

endmodule

// ==== logic/iClassPkg.sv ====
/* Instruction class package
   Shared word and class types, opcode constants and the 32-bit class rules */
package iClassPkg;

  // Instruction word, raw fetch or decode form
  typedef logic [31:0] instr_t;
  // Class vector {call, return, jump, branch}
  typedef logic [3:0]  iClass_t;

  // Bit positions inside iClass_t
  localparam int clsCall   = 3;
  localparam int clsRet    = 2;
  localparam int clsJump   = 1;
  localparam int clsBranch = 0;

  // Full-width opcodes
  localparam logic [6:0] opcJal    = 7'h6F;
  localparam logic [6:0] opcJalr   = 7'h67;
  localparam logic [6:0] opcBranch = 7'h63;

  // Compressed opcodes as {bits 1:0, bits 15:13}
  localparam logic [4:0] cOpcJal        = 5'h09;
  localparam logic [4:0] cOpcJ          = 5'h0D;
  // C.JR / C.JALR share this, bit 12 picks the link form
  localparam logic [4:0] cOpcJrGroup    = 5'h14;
  // C.BEQZ at 0E, C.BNEZ at 0F, compared on the top 4 bits
  localparam logic [4:0] cOpcBranchPair = 5'h0E;

  // Link register match, hits x1 and x5
  localparam logic [4:0] linkMask  = 5'h1B;
  localparam logic [4:0] linkMatch = 5'h01;

  function automatic logic isLink(input logic [4:0] regIdx);
    return (regIdx & linkMask) == linkMatch;
  endfunction

  // Class of a 32-bit encoding
  function automatic iClass_t classify32(input instr_t instr);
    logic jump;
    logic branch;
    jump   = (instr[6:0] == opcJal) || (instr[6:0] == opcJalr);
    branch = instr[6:0] == opcBranch;
    // Return reads rs1, call writes rd
    return {jump & isLink(instr[11:7]), jump & isLink(instr[19:15]), jump, branch};
  endfunction

endpackage

// ==== logic/iClassPred.sv ====
/* Instruction class predictor
   Fetch predecode, decode check and class pipeline for a RISC-V fetch unit */
`timescale 1ns/1ps

module iClassPred
  import iClassPkg::*;
#(
  parameter bit cSupported = 1'b1,
  parameter int xlen       = 32
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    stallD,
  input  logic    stallE,
  input  logic    stallM,
  input  logic    stallW,
  input  logic    flushD,
  input  logic    flushE,
  input  logic    flushM,
  input  logic    flushW,
  input  instr_t  instrRawF,
  input  instr_t  instrD,
  output iClass_t bpClassF,
  output iClass_t classD,
  output iClass_t classE,
  output iClass_t classM,
  output iClass_t classW,
  output logic    returnWrongD,
  output logic    classWrongE,
  output logic    classWrongM
);

  // Registered prediction for the word now in Decode
  iClass_t bpClassD;

  // D-stage class bundle
  classBus dBusD ();

  // Input side, predicted class from the raw fetch word
  fetchPredecode #(
    .cSupported(cSupported),
    .xlen      (xlen)
  ) uFetchPredecode (
    .clk      (clk),
    .arstN    (arstN),
    .stallD   (stallD),
    .flushD   (flushD),
    .instrRawF(instrRawF),
    .bpClassF (bpClassF),
    .bpClassD (bpClassD)
  );

  // Decode check against the prediction
  decodeClassify uDecodeClassify (
    .instrD      (instrD),
    .bpClassD    (bpClassD),
    .returnWrongD(returnWrongD),
    .dBus        (dBusD.sender)
  );

  // Output side, E/M/W registers
  classPipe uClassPipe (
    .clk        (clk),
    .arstN      (arstN),
    .stallE     (stallE),
    .stallM     (stallM),
    .stallW     (stallW),
    .flushE     (flushE),
    .flushM     (flushM),
    .flushW     (flushW),
    .dBus       (dBusD.receiver),
    .classE     (classE),
    .classM     (classM),
    .classW     (classW),
    .classWrongE(classWrongE),
    .classWrongM(classWrongM)
  );

  assign classD = {dBusD.call, dBusD.ret, dBusD.jump, dBusD.branch};

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the class predictor testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f iClassPred.f --top-module iClassPredTb -o simv \
  && ./obj_dir/simv | tee /dev/stderr | grep -q "Done: no errors" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== verification/iClassPredTb.sv ====
/* Testbench for the instruction class predictor
   Reference decode, shadow stage model and per-cycle output compare */
`timescale 1ns/1ps

module iClassPredTb
  import iClassPkg::*;
();

  // Canonical ADDI x0,x0,0 with no class bits
  localparam instr_t nopWord = 32'h0000_0013;
  localparam int drainLimit = 20;

  logic    clk = 1'b0;
  logic    arstN;
  logic    stallD, stallE, stallM, stallW;
  logic    flushD, flushE, flushM, flushW;
  instr_t  instrRawF;
  instr_t  instrD;
  iClass_t bpClassF, classD, classE, classM, classW;
  logic    returnWrongD, classWrongE, classWrongM;

  // Shadow stage registers
  iClass_t mPredD, mE, mM, mW;
  logic    mWrongE, mWrongM;

  integer  seed;
  logic    checkEn = 1'b0;
  logic    wrongSeen = 1'b0;
  instr_t  directed[$];

  always #5 clk = ~clk;

  iClassPred #(
    .cSupported(1'b1),
    .xlen      (32)
  ) u_iClassPred (
    .clk(clk), .arstN(arstN),
    .stallD(stallD), .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushD(flushD), .flushE(flushE), .flushM(flushM), .flushW(flushW),
    .instrRawF(instrRawF), .instrD(instrD),
    .bpClassF(bpClassF), .classD(classD), .classE(classE), .classM(classM),
    .classW(classW), .returnWrongD(returnWrongD),
    .classWrongE(classWrongE), .classWrongM(classWrongM)
  );

  ////////////////////////////////////////////////////////////
  // Reference decode
  ////////////////////////////////////////////////////////////

  // x1 or x5
  function automatic logic linkReg(input logic [4:0] r);
    return (r == 5'd1) || (r == 5'd5);
  endfunction

  function automatic iClass_t refClassify(input instr_t w);
    logic j;
    j = (w[6:0] == 7'h6F) || (w[6:0] == 7'h67);
    // {call on rd, return on rs1, jump, branch}
    return {j & linkReg(w[11:7]), j & linkReg(w[19:15]), j, w[6:0] == 7'h63};
  endfunction

  // RV32 with compressed support
  function automatic iClass_t refPredecode(input instr_t w);
    iClass_t c;
    logic [4:0] rs1;
    c = '0;
    rs1 = w[11:7];
    if (w[1:0] == 2'b11) begin
      c = refClassify(w);
    end else begin
      case ({w[1:0], w[15:13]})
        5'b01001: c = 4'b1010;
        5'b01101: c = 4'b0010;
        5'b01110, 5'b01111: c = 4'b0001;
        // C.JR and C.JALR need rs2 zero and rs1 nonzero
        5'b10100: if (w[6:2] == 5'd0 && rs1 != 5'd0) begin
          c = {w[12] & linkReg(rs1), linkReg(rs1), 1'b1, 1'b0};
        end
        default: c = '0;
      endcase
    end
    return c;
  endfunction

  // Encoders for directed words
  function automatic instr_t encJump(input logic [6:0] opc, input logic [4:0] rd,
                                     input logic [4:0] rs1);
    return {12'h000, rs1, 3'b000, rd, opc};
  endfunction

  function automatic instr_t encCr(input logic b12, input logic [4:0] rs1,
                                   input logic [4:0] rs2);
    return {16'hA5A5, 3'b100, b12, rs1, rs2, 2'b10};
  endfunction

  function automatic instr_t encCi(input logic [2:0] funct3);
    return {16'h0000, funct3, 11'h155, 2'b01};
  endfunction

  // True one time in four
  function automatic logic rollBit();
    return ($random(seed) & 32'h3) == 32'h0;
  endfunction

  // Half directed, half raw random
  function automatic instr_t pickWord();
    int idx;
    if (($random(seed) & 32'h1) == 32'h0) begin
      idx = ($random(seed) & 32'h7FFF_FFFF) % directed.size();
      return directed[idx];
    end
    return $random(seed);
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abortRun();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic checkClass(input string name, input iClass_t expVal, input iClass_t actVal);
    if (actVal !== expVal) begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, expVal, actVal);
      abortRun();
    end
  endtask

  task automatic checkBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      $display("FAIL t=%0t %s expected %b got %b", $time, name, expVal, actVal);
      abortRun();
    end
  endtask

  // Shadow model with enable then clear per stage
  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mPredD  <= '0;
      mE      <= '0;
      mM      <= '0;
      mW      <= '0;
      mWrongE <= 1'b0;
      mWrongM <= 1'b0;
    end else begin
      if (!stallD) mPredD <= flushD ? '0 : refPredecode(instrRawF);
      if (!stallE) begin
        mE      <= flushE ? '0 : refClassify(instrD);
        mWrongE <= flushE ? 1'b0 : (refClassify(instrD) != mPredD);
      end
      if (!stallM) begin
        mM      <= flushM ? '0 : mE;
        mWrongM <= flushM ? 1'b0 : mWrongE;
      end
      if (!stallW) mW <= flushW ? '0 : mM;
    end
  end

  // Outputs settle well before the falling edge
  always @(negedge clk) begin : compareOutputs
    iClass_t expD;
    expD = refClassify(instrD);
    if (checkEn) begin
      checkClass("bpClassF", refPredecode(instrRawF), bpClassF);
      checkClass("classD", expD, classD);
      checkBit("returnWrongD", mPredD[clsRet] ^ expD[clsRet], returnWrongD);
      checkClass("classE", mE, classE);
      checkClass("classM", mM, classM);
      checkClass("classW", mW, classW);
      checkBit("classWrongE", mWrongE, classWrongE);
      checkBit("classWrongM", mWrongM, classWrongM);
      if (classWrongE) wrongSeen = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // One edge where D follows fetch unless swapped for a mispredict
  task automatic stepCycle(input instr_t raw, input logic swap, input logic perturb);
    instr_t nextD;
    @(posedge clk);
    if (stallD) nextD = instrD;
    else if (flushD) nextD = nopWord;
    else nextD = instrRawF;
    if (swap) nextD = pickWord();
    instrD    <= nextD;
    instrRawF <= raw;
    stallD <= perturb & rollBit();
    stallE <= perturb & rollBit();
    stallM <= perturb & rollBit();
    stallW <= perturb & rollBit();
    flushD <= perturb & rollBit() & rollBit();
    flushE <= perturb & rollBit() & rollBit();
    flushM <= perturb & rollBit() & rollBit();
    flushW <= perturb & rollBit() & rollBit();
  endtask

  function automatic logic pipeBusy();
    return (classE != '0) || (classM != '0) || (classW != '0) || classWrongM;
  endfunction

  // Feed NOPs until every stage is empty
  task automatic drainPipe();
    int waitCycles;
    waitCycles = 0;
    stepCycle(nopWord, 1'b0, 1'b0);
    @(negedge clk);
    while (pipeBusy() && waitCycles < drainLimit) begin
      stepCycle(nopWord, 1'b0, 1'b0);
      @(negedge clk);
      waitCycles++;
    end
    if (pipeBusy()) begin
      $display("Timeout: class pipeline did not drain to zero");
      abortRun();
    end
  endtask

  initial begin : stimulus
    logic [4:0] regs [4];
    seed = 32'ha1a5;
    regs = '{5'd1, 5'd5, 5'd2, 5'd0};
    arstN = 1'b0;
    {stallD, stallE, stallM, stallW} = 4'b0;
    {flushD, flushE, flushM, flushW} = 4'b0;
    instrRawF = '0;
    instrD    = '0;
    // Every jump form against link and non-link registers
    for (int a = 0; a < 4; a++) begin
      for (int b = 0; b < 3; b++) begin
        directed.push_back(encJump(7'h6F, regs[a], regs[b]));
        directed.push_back(encJump(7'h67, regs[a], regs[b]));
      end
      directed.push_back(encCr(1'b0, regs[a], 5'd0));
      directed.push_back(encCr(1'b1, regs[a], 5'd0));
      // C.MV and C.ADD are not jumps
      directed.push_back(encCr(1'b1, regs[a], 5'd3));
      directed.push_back({7'h00, 5'd2, regs[a], 3'b001, 5'd0, 7'h63});
    end
    // C.JAL, C.J, C.BEQZ, C.BNEZ
    directed.push_back(encCi(3'b001));
    directed.push_back(encCi(3'b101));
    directed.push_back(encCi(3'b110));
    directed.push_back(encCi(3'b111));
    directed.push_back(nopWord);

    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    checkClass("classE", 4'h0, classE);
    checkClass("classM", 4'h0, classM);
    checkClass("classW", 4'h0, classW);
    checkBit("returnWrongD", 1'b0, returnWrongD);
    checkBit("classWrongE", 1'b0, classWrongE);
    checkBit("classWrongM", 1'b0, classWrongM);
    checkEn = 1'b1;

    // Plain advance, then mispredicts, then stall and flush
    foreach (directed[k]) stepCycle(directed[k], 1'b0, 1'b0);
    for (int i = 0; i < 200; i++) stepCycle(pickWord(), rollBit(), 1'b0);
    for (int i = 0; i < 500; i++) stepCycle(pickWord(), rollBit(), 1'b1);
    drainPipe();

    if (wrongSeen) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("No class misprediction reached the Execute stage");
      abortRun();
    end
  end

endmodule
